/* flist.f */
rtl/lc4_pkg.sv
rtl/lc4_regfile.sv
rtl/lc4_decode.sv
rtl/insn_queue.sv
rtl/lc4_execute.sv
rtl/lc4_core.sv
bench/lc4_core_sva.sv
bench/tb_lc4_core.sv

/* bench/tb_lc4_core.sv */
`timescale 1ns/1ps

module tb_lc4_core
    import lc4_pkg::*;
();
    localparam int TIMEOUT = 200;

    logic     gwe = 1'b0;
    logic     i_arst_n;
    logic     i_insn_valid;
    word_t    i_insn;
    logic     o_insn_ready;
    logic     o_ret_valid;
    logic     i_ret_ready;
    word_t    o_ret_insn;
    logic     o_ret_we;
    reg_idx_t o_ret_wsel;
    word_t    o_ret_data;
    nzp_t     o_ret_nzp;

    // reference model state and expected retire records
    word_t       model_regs [8];
    word_t       exp_insn [$];
    logic        exp_we [$];
    reg_idx_t    exp_wsel [$];
    word_t       exp_data [$];
    nzp_t        exp_nzp [$];
    word_t       last_ret_data;
    logic [15:0] lfsr = 16'd66;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_passed = 0;
    // 0 always ready, 1 random gaps, 2 stalled
    int          ret_mode = 0;
    logic        rand_gaps = 1'b0;

    lc4_core #(.QUEUE_DEPTH(4)) DUT (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_insn_valid (i_insn_valid),
        .i_insn       (i_insn),
        .o_insn_ready (o_insn_ready),
        .o_ret_valid  (o_ret_valid),
        .i_ret_ready  (i_ret_ready),
        .o_ret_insn   (o_ret_insn),
        .o_ret_we     (o_ret_we),
        .o_ret_wsel   (o_ret_wsel),
        .o_ret_data   (o_ret_data),
        .o_ret_nzp    (o_ret_nzp)
    );

    always #20 gwe = ~gwe;

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[14:0], fb};
        end
        return val;
    endfunction

    // kind 0 arith, 1 logic, 2 mixed, 3 unsupported only
    function automatic word_t make_insn(input int kind);
        logic [15:0] k;
        logic [15:0] bits;
        logic [3:0]  opc;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        int          grp;
        word_t       insn;
        grp = (kind == 3) ? 2 : kind;
        if (kind == 2) begin
            k   = take_bits(2);
            grp = (k == 0) ? 2 : (k == 1) ? 0 : 1;
        end
        // narrow register range in directed groups gives more dependencies
        rd   = reg_idx_t'(take_bits(kind >= 2 ? 3 : 2));
        rs   = reg_idx_t'(take_bits(kind >= 2 ? 3 : 2));
        rt   = reg_idx_t'(take_bits(kind >= 2 ? 3 : 2));
        bits = take_bits(9);
        k    = take_bits(3);
        case (grp)
            0: begin
                case (k)
                    0, 1:    insn = {4'h9, rd, bits[8:0]};
                    2:       insn = {4'h1, rd, rs, 3'b000, rt};
                    3:       insn = {4'h1, rd, rs, 3'b001, rt};
                    4:       insn = {4'h1, rd, rs, 3'b010, rt};
                    default: insn = {4'h1, rd, rs, 1'b1, bits[4:0]};
                endcase
            end
            1: begin
                case (k)
                    0:       insn = {4'h5, rd, rs, 3'b000, rt};
                    1:       insn = {4'h5, rd, rs, 3'b001, rt};
                    2:       insn = {4'h5, rd, rs, 3'b010, rt};
                    3:       insn = {4'h5, rd, rs, 3'b011, rt};
                    4:       insn = {4'h5, rd, rs, 1'b1, bits[4:0]};
                    5:       insn = {4'h9, rd, bits[8:0]};
                    default: insn = {4'hD, rd, 1'b1, bits[7:0]};
                endcase
            end
            default: begin
                opc = 4'(take_bits(4));
                if (opc[1:0] == 2'b01) begin
                    opc[1:0] = 2'b11;
                end
                insn = {opc, rd, bits[8:0]};
            end
        endcase
        return insn;
    endfunction

    // LC4 semantics applied in program order at acceptance
    task automatic model_accept(input word_t insn);
        reg_idx_t rd;
        logic [2:0] sub;
        word_t a;
        word_t b;
        word_t imm5;
        word_t res;
        logic we;
        nzp_t nzp;
        rd   = insn[11:9];
        sub  = insn[5:3];
        a    = model_regs[insn[8:6]];
        b    = model_regs[insn[2:0]];
        imm5 = {{11{insn[4]}}, insn[4:0]};
        we   = 1'b1;
        res  = '0;
        case (insn[15:12])
            4'h1: begin
                if (sub[2]) begin
                    res = a + imm5;
                end else begin
                    case (sub[1:0])
                        2'd0:    res = a + b;
                        2'd1:    res = a * b;
                        2'd2:    res = a - b;
                        default: we = 1'b0;
                    endcase
                end
            end
            4'h5: begin
                if (sub[2]) begin
                    res = a & imm5;
                end else begin
                    case (sub[1:0])
                        2'd0:    res = a & b;
                        2'd1:    res = ~a;
                        2'd2:    res = a | b;
                        default: res = a ^ b;
                    endcase
                end
            end
            4'h9:    res = {{7{insn[8]}}, insn[8:0]};
            4'hD:    res = {insn[7:0], model_regs[rd][7:0]};
            default: we = 1'b0;
        endcase
        nzp = res[15] ? 3'b100 : (res == '0) ? 3'b010 : 3'b001;
        if (we) begin
            model_regs[rd] = res;
        end
        exp_insn.push_back(insn);
        exp_we.push_back(we);
        exp_wsel.push_back(rd);
        exp_data.push_back(res);
        exp_nzp.push_back(nzp);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got r%0d expected r%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_nzp(input nzp_t got, input nzp_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_retire();
        logic e_we;
        reg_idx_t e_wsel;
        word_t e_data;
        nzp_t e_nzp;
        if (exp_insn.size() == 0) begin
            $display("retire of %h at %0t ns with nothing outstanding", o_ret_insn, $time);
            errors++;
            return;
        end
        check_word(o_ret_insn, exp_insn.pop_front(), "retire insn");
        e_we   = exp_we.pop_front();
        e_wsel = exp_wsel.pop_front();
        e_data = exp_data.pop_front();
        e_nzp  = exp_nzp.pop_front();
        check_bit(o_ret_we, e_we, "retire we");
        if (e_we) begin
            check_reg(o_ret_wsel, e_wsel, "retire wsel");
            check_word(o_ret_data, e_data, "retire data");
            check_nzp(o_ret_nzp, e_nzp, "retire nzp");
        end
        last_ret_data = o_ret_data;
    endtask

    // drive on the falling edge, both handshakes are settled until the next rise
    task automatic clock_cycle(input logic v, input word_t insn, output logic took);
        logic rr;
        @(negedge gwe);
        case (ret_mode)
            0:       rr = 1'b1;
            1:       rr = (take_bits(2) != 0);
            default: rr = 1'b0;
        endcase
        i_insn_valid = v;
        i_insn       = insn;
        i_ret_ready  = rr;
        took = v && o_insn_ready;
        if (took) begin
            model_accept(insn);
        end
        if (o_ret_valid && i_ret_ready) begin
            check_retire();
        end
    endtask

    task automatic send_insn(input word_t insn);
        logic took;
        int n;
        if (rand_gaps) begin
            n = take_bits(2);
            repeat (n) clock_cycle(1'b0, '0, took);
        end
        took = 1'b0;
        n = 0;
        while (!took && n < TIMEOUT) begin
            clock_cycle(1'b1, insn, took);
            n++;
        end
        if (!took) begin
            $display("timeout: instruction %h was never accepted", insn);
            errors++;
        end
    endtask

    task automatic drain_pipe();
        logic took;
        int n;
        n = 0;
        while (exp_insn.size() > 0 && n < TIMEOUT) begin
            clock_cycle(1'b0, '0, took);
            n++;
        end
        if (exp_insn.size() > 0) begin
            $display("timeout: %0d instructions never retired", exp_insn.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int err0;
        word_t insn;
        logic took;
        logic dropped;
        int n;
        int sva_fails;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        i_arst_n     = 1'b1;
        i_insn_valid = 1'b0;
        i_insn       = '0;
        i_ret_ready  = 1'b0;
        // reset falls after time zero so every flop sees the edge
        #1;
        i_arst_n = 1'b0;
        repeat (3) @(posedge gwe);
        @(negedge gwe);
        i_arst_n = 1'b1;

        err0 = errors;
        check_bit(o_ret_valid, 1'b0, "o_ret_valid after reset");
        check_bit(o_insn_ready, 1'b1, "o_insn_ready after reset");
        // NOT r1, r0
        send_insn(16'h5208);
        drain_pipe();
        check_word(last_ret_data, 16'hFFFF, "not of reset r0");
        end_test("reset_and_not", err0);

        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            send_insn(make_insn(0));
        end
        drain_pipe();
        end_test("arith_bypass", err0);

        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            send_insn(make_insn(1));
        end
        drain_pipe();
        end_test("logic_const", err0);

        err0 = errors;
        for (int i = 0; i < 12; i++) begin
            insn = make_insn(3);
            send_insn(insn);
            // ADDI rd, rd, #0 reads back the register named by the no-op
            send_insn({4'h1, insn[11:9], insn[11:9], 1'b1, 5'd0});
        end
        drain_pipe();
        end_test("unsupported_nop", err0);

        err0 = errors;
        ret_mode  = 1;
        rand_gaps = 1'b1;
        for (int i = 0; i < 80; i++) begin
            send_insn(make_insn(2));
        end
        drain_pipe();
        end_test("random_order", err0);

        err0 = errors;
        ret_mode  = 2;
        rand_gaps = 1'b0;
        insn    = make_insn(1);
        dropped = 1'b0;
        n = 0;
        while (!dropped && n < 40) begin
            clock_cycle(1'b1, insn, took);
            if (took) begin
                insn = make_insn(1);
            end else begin
                dropped = 1'b1;
            end
            n++;
        end
        if (!dropped) begin
            $display("timeout: o_insn_ready stayed high under a retire stall");
            errors++;
        end
        ret_mode = 0;
        send_insn(insn);
        drain_pipe();
        end_test("stall_backpressure", err0);

        sva_fails = DUT.u_decode.u_dec_sva.fail_count + DUT.u_execute.u_ret_sva.fail_count;
        if (sva_fails != 0) begin
            $display("%0d bound assertions failed during the run", sva_fails);
            errors += sva_fails;
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* bench/lc4_core_sva.sv */
`timescale 1ns/1ps

module handshake_sva
    import lc4_pkg::*;
(
    input logic  gwe,
    input logic  i_arst_n,
    input logic  i_valid,
    input logic  i_ready,
    input word_t i_payload_a,
    input word_t i_payload_b
);
    // number of assertion failures seen so far
    int fail_count = 0;

    // a stalled entry keeps its valid and its payload
    hold_while_stalled: assert property (
        @(posedge gwe) disable iff (!i_arst_n)
        i_valid && !i_ready |=> i_valid && $stable(i_payload_a) && $stable(i_payload_b)
    ) else begin
        $error("stream entry changed while stalled");
        fail_count++;
    end

    // no valid entry may appear while reset is held
    quiet_in_reset: assert property (
        @(posedge gwe) !i_arst_n |-> !i_valid
    ) else begin
        $error("valid high during reset");
        fail_count++;
    end

endmodule

// decoded stream out of the decoder
bind lc4_decode handshake_sva u_dec_sva (
    .gwe         (gwe),
    .i_arst_n    (i_arst_n),
    .i_valid     (o_dec_valid),
    .i_ready     (i_dec_ready),
    .i_payload_a (o_dec_insn),
    .i_payload_b (o_dec_imm)
);

// retire stream out of writeback
bind lc4_execute handshake_sva u_ret_sva (
    .gwe         (gwe),
    .i_arst_n    (i_arst_n),
    .i_valid     (o_ret_valid),
    .i_ready     (i_ret_ready),
    .i_payload_a (o_ret_insn),
    .i_payload_b (o_ret_data)
);

/* rtl/lc4_core.sv */
`timescale 1ns/1ps

module lc4_core
    import lc4_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     gwe,
    input  logic     i_arst_n,
    input  logic     i_insn_valid,
    input  word_t    i_insn,
    output logic     o_insn_ready,
    output logic     o_ret_valid,
    input  logic     i_ret_ready,
    output word_t    o_ret_insn,
    output logic     o_ret_we,
    output reg_idx_t o_ret_wsel,
    output word_t    o_ret_data,
    output nzp_t     o_ret_nzp
);
    // decode to queue
    logic     dec_valid;
    logic     dec_ready;
    word_t    dec_insn;
    alu_op_e  dec_op;
    reg_idx_t dec_rd;
    reg_idx_t dec_rs;
    reg_idx_t dec_rt;
    imm_t     dec_imm;
    logic     dec_we;

    // queue to execute
    logic     iss_valid;
    logic     iss_ready;
    word_t    iss_insn;
    alu_op_e  iss_op;
    reg_idx_t iss_rd;
    reg_idx_t iss_rs;
    reg_idx_t iss_rt;
    imm_t     iss_imm;
    logic     iss_we;

    // register file ports
    reg_idx_t rf_rs;
    reg_idx_t rf_rt;
    word_t    rf_rs_data;
    word_t    rf_rt_data;
    logic     rf_we;
    reg_idx_t rf_wsel;
    word_t    rf_wdata;

    lc4_decode u_decode (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_insn_valid (i_insn_valid),
        .i_insn       (i_insn),
        .o_insn_ready (o_insn_ready),
        .o_dec_valid  (dec_valid),
        .i_dec_ready  (dec_ready),
        .o_dec_insn   (dec_insn),
        .o_dec_op     (dec_op),
        .o_dec_rd     (dec_rd),
        .o_dec_rs     (dec_rs),
        .o_dec_rt     (dec_rt),
        .o_dec_imm    (dec_imm),
        .o_dec_we     (dec_we)
    );

    insn_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_push_valid (dec_valid),
        .o_push_ready (dec_ready),
        .i_push_insn  (dec_insn),
        .i_push_op    (dec_op),
        .i_push_rd    (dec_rd),
        .i_push_rs    (dec_rs),
        .i_push_rt    (dec_rt),
        .i_push_imm   (dec_imm),
        .i_push_we    (dec_we),
        .o_pop_valid  (iss_valid),
        .i_pop_ready  (iss_ready),
        .o_pop_insn   (iss_insn),
        .o_pop_op     (iss_op),
        .o_pop_rd     (iss_rd),
        .o_pop_rs     (iss_rs),
        .o_pop_rt     (iss_rt),
        .o_pop_imm    (iss_imm),
        .o_pop_we     (iss_we)
    );

    lc4_execute u_execute (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_iss_valid  (iss_valid),
        .o_iss_ready  (iss_ready),
        .i_iss_insn   (iss_insn),
        .i_iss_op     (iss_op),
        .i_iss_rd     (iss_rd),
        .i_iss_rs     (iss_rs),
        .i_iss_rt     (iss_rt),
        .i_iss_imm    (iss_imm),
        .i_iss_we     (iss_we),
        .o_rf_rs      (rf_rs),
        .o_rf_rt      (rf_rt),
        .i_rf_rs_data (rf_rs_data),
        .i_rf_rt_data (rf_rt_data),
        .o_rf_we      (rf_we),
        .o_rf_wsel    (rf_wsel),
        .o_rf_wdata   (rf_wdata),
        .o_ret_valid  (o_ret_valid),
        .i_ret_ready  (i_ret_ready),
        .o_ret_insn   (o_ret_insn),
        .o_ret_we     (o_ret_we),
        .o_ret_wsel   (o_ret_wsel),
        .o_ret_data   (o_ret_data),
        .o_ret_nzp    (o_ret_nzp)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs      (rf_rs),
        .i_rt      (rf_rt),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data),
        .i_we      (rf_we),
        .i_wsel    (rf_wsel),
        .i_wdata   (rf_wdata)
    );

endmodule

/* rtl/lc4_execute.sv */
`timescale 1ns/1ps

module lc4_execute
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_arst_n,
    input  logic     i_iss_valid,
    output logic     o_iss_ready,
    input  word_t    i_iss_insn,
    input  alu_op_e  i_iss_op,
    input  reg_idx_t i_iss_rd,
    input  reg_idx_t i_iss_rs,
    input  reg_idx_t i_iss_rt,
    input  imm_t     i_iss_imm,
    input  logic     i_iss_we,
    output reg_idx_t o_rf_rs,
    output reg_idx_t o_rf_rt,
    input  word_t    i_rf_rs_data,
    input  word_t    i_rf_rt_data,
    output logic     o_rf_we,
    output reg_idx_t o_rf_wsel,
    output word_t    o_rf_wdata,
    output logic     o_ret_valid,
    input  logic     i_ret_ready,
    output word_t    o_ret_insn,
    output logic     o_ret_we,
    output reg_idx_t o_ret_wsel,
    output word_t    o_ret_data,
    output nzp_t     o_ret_nzp
);
    // execute stage
    logic     x_valid;
    word_t    x_insn;
    alu_op_e  x_op;
    reg_idx_t x_rd;
    reg_idx_t x_rs;
    reg_idx_t x_rt;
    imm_t     x_imm;
    logic     x_we;

    word_t    rs_val;
    word_t    rt_val;
    word_t    alu_result;
    nzp_t     alu_nzp;
    logic     w_advance;

    assign o_rf_rs = x_rs;
    assign o_rf_rt = x_rt;

    // WX bypass, writeback holds the only write not yet in the register file
    assign rs_val = (o_ret_valid && o_ret_we && o_ret_wsel == x_rs) ? o_ret_data : i_rf_rs_data;
    assign rt_val = (o_ret_valid && o_ret_we && o_ret_wsel == x_rt) ? o_ret_data : i_rf_rt_data;

    always_comb begin
        case (x_op)
            ALU_ADD:     alu_result = rs_val + rt_val;
            ALU_SUB:     alu_result = rs_val - rt_val;
            ALU_MUL:     alu_result = rs_val * rt_val;
            ALU_ADDI:    alu_result = rs_val + x_imm;
            ALU_AND:     alu_result = rs_val & rt_val;
            ALU_OR:      alu_result = rs_val | rt_val;
            ALU_XOR:     alu_result = rs_val ^ rt_val;
            ALU_NOT:     alu_result = ~rs_val;
            ALU_ANDI:    alu_result = rs_val & x_imm;
            ALU_CONST:   alu_result = x_imm;
            ALU_HICONST: alu_result = {x_imm[7:0], rs_val[7:0]};
            default:     alu_result = '0;
        endcase
    end

    // condition code follows the signed result
    always_comb begin
        if (alu_result[XLEN-1]) begin
            alu_nzp = NZP_NEG;
        end else if (alu_result == '0) begin
            alu_nzp = NZP_ZERO;
        end else begin
            alu_nzp = NZP_POS;
        end
    end

    assign w_advance   = ~o_ret_valid | i_ret_ready;
    assign o_iss_ready = ~x_valid | w_advance;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_valid     <= 1'b0;
            o_ret_valid <= 1'b0;
        end else begin
            if (o_iss_ready) begin
                x_valid <= i_iss_valid;
            end
            if (w_advance) begin
                o_ret_valid <= x_valid;
            end
        end
    end

    always_ff @(posedge gwe) begin
        if (o_iss_ready && i_iss_valid) begin
            x_insn <= i_iss_insn;
            x_op   <= i_iss_op;
            x_rd   <= i_iss_rd;
            x_rs   <= i_iss_rs;
            x_rt   <= i_iss_rt;
            x_imm  <= i_iss_imm;
            x_we   <= i_iss_we;
        end
        if (w_advance && x_valid) begin
            o_ret_insn <= x_insn;
            o_ret_we   <= x_we;
            o_ret_wsel <= x_rd;
            o_ret_data <= alu_result;
            o_ret_nzp  <= alu_nzp;
        end
    end

    // commit happens on the retire handshake
    assign o_rf_we    = o_ret_valid & o_ret_we & i_ret_ready;
    assign o_rf_wsel  = o_ret_wsel;
    assign o_rf_wdata = o_ret_data;

endmodule

/* rtl/insn_queue.sv */
`timescale 1ns/1ps

module insn_queue
    import lc4_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     gwe,
    input  logic     i_arst_n,
    input  logic     i_push_valid,
    output logic     o_push_ready,
    input  word_t    i_push_insn,
    input  alu_op_e  i_push_op,
    input  reg_idx_t i_push_rd,
    input  reg_idx_t i_push_rs,
    input  reg_idx_t i_push_rt,
    input  imm_t     i_push_imm,
    input  logic     i_push_we,
    output logic     o_pop_valid,
    input  logic     i_pop_ready,
    output word_t    o_pop_insn,
    output alu_op_e  o_pop_op,
    output reg_idx_t o_pop_rd,
    output reg_idx_t o_pop_rs,
    output reg_idx_t o_pop_rt,
    output imm_t     o_pop_imm,
    output logic     o_pop_we
);
    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int ENTRY_W = $bits(word_t) + $bits(alu_op_e) + 3 * $bits(reg_idx_t)
                           + $bits(imm_t) + 1;

    logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic [3:0]         pop_op_bits;
    logic               push;
    logic               pop;

    assign o_push_ready = (count != QUEUE_DEPTH[PTR_W:0]);
    assign o_pop_valid  = (count != '0);
    assign push         = i_push_valid & o_push_ready;
    assign pop          = o_pop_valid & i_pop_ready;

    // head entry is read straight out of the array
    assign {o_pop_insn, pop_op_bits, o_pop_rd, o_pop_rs, o_pop_rt,
            o_pop_imm, o_pop_we} = mem[rd_ptr];
    assign o_pop_op = alu_op_e'(pop_op_bits);

    always_ff @(posedge gwe) begin
        if (push) begin
            mem[wr_ptr] <= {i_push_insn, i_push_op, i_push_rd, i_push_rs, i_push_rt,
                            i_push_imm, i_push_we};
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* rtl/lc4_decode.sv */
`timescale 1ns/1ps

module lc4_decode
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_arst_n,
    input  logic     i_insn_valid,
    input  word_t    i_insn,
    output logic     o_insn_ready,
    output logic     o_dec_valid,
    input  logic     i_dec_ready,
    output word_t    o_dec_insn,
    output alu_op_e  o_dec_op,
    output reg_idx_t o_dec_rd,
    output reg_idx_t o_dec_rs,
    output reg_idx_t o_dec_rt,
    output imm_t     o_dec_imm,
    output logic     o_dec_we
);
    opcode_e    opcode;
    logic [2:0] sub_op;
    alu_op_e    op_next;
    reg_idx_t   rs_next;
    imm_t       imm_next;
    logic       we_next;
    logic       accept;

    assign opcode = opcode_e'(i_insn[15:12]);
    assign sub_op = i_insn[5:3];

    always_comb begin
        op_next  = ALU_NOP;
        rs_next  = i_insn[8:6];
        imm_next = '0;
        we_next  = 1'b1;
        case (opcode)
            OPC_ARITH: begin
                // sub_op 1xx selects the imm5 form
                case (sub_op)
                    3'b000:  op_next = ALU_ADD;
                    3'b001:  op_next = ALU_MUL;
                    3'b010:  op_next = ALU_SUB;
                    3'b011:  we_next = 1'b0;
                    default: op_next = ALU_ADDI;
                endcase
                imm_next = {{(XLEN-5){i_insn[4]}}, i_insn[4:0]};
            end
            OPC_LOGIC: begin
                case (sub_op)
                    3'b000:  op_next = ALU_AND;
                    3'b001:  op_next = ALU_NOT;
                    3'b010:  op_next = ALU_OR;
                    3'b011:  op_next = ALU_XOR;
                    default: op_next = ALU_ANDI;
                endcase
                imm_next = {{(XLEN-5){i_insn[4]}}, i_insn[4:0]};
            end
            OPC_CONST: begin
                op_next  = ALU_CONST;
                imm_next = {{(XLEN-9){i_insn[8]}}, i_insn[8:0]};
            end
            OPC_HICONST: begin
                // old rd value supplies the low byte
                op_next  = ALU_HICONST;
                rs_next  = i_insn[11:9];
                imm_next = {8'h00, i_insn[7:0]};
            end
            default: we_next = 1'b0;
        endcase
    end

    // single entry, refilled when empty or drained this cycle
    assign o_insn_ready = ~o_dec_valid | i_dec_ready;
    assign accept       = i_insn_valid & o_insn_ready;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_dec_valid <= 1'b0;
        end else if (o_insn_ready) begin
            o_dec_valid <= i_insn_valid;
        end
    end

    always_ff @(posedge gwe) begin
        if (accept) begin
            o_dec_insn <= i_insn;
            o_dec_op   <= op_next;
            o_dec_rd   <= i_insn[11:9];
            o_dec_rs   <= rs_next;
            o_dec_rt   <= i_insn[2:0];
            o_dec_imm  <= imm_next;
            o_dec_we   <= we_next;
        end
    end

endmodule

/* rtl/lc4_regfile.sv */
`timescale 1ns/1ps

module lc4_regfile
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_arst_n,
    input  reg_idx_t i_rs,
    input  reg_idx_t i_rt,
    output word_t    o_rs_data,
    output word_t    o_rt_data,
    input  logic     i_we,
    input  reg_idx_t i_wsel,
    input  word_t    i_wdata
);
    word_t regs [8];

    // reads see the old value during a write, the execute stage bypasses
    assign o_rs_data = regs[i_rs];
    assign o_rt_data = regs[i_rt];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

endmodule

/* rtl/lc4_pkg.sv */
package lc4_pkg;

    // datapath width of the LC4 machine
    parameter int XLEN = 16;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [2:0]      reg_idx_t;

    // one-hot condition code, bit order is N Z P
    typedef logic [2:0]      nzp_t;

    // immediates are carried already extended to a full word
    typedef word_t           imm_t;

    localparam nzp_t NZP_NEG  = 3'b100;
    localparam nzp_t NZP_ZERO = 3'b010;
    localparam nzp_t NZP_POS  = 3'b001;

    // top four instruction bits of the ALU-class groups
    typedef enum logic [3:0] {
        OPC_ARITH   = 4'b0001,
        OPC_LOGIC   = 4'b0101,
        OPC_CONST   = 4'b1001,
        OPC_HICONST = 4'b1101
    } opcode_e;

    // operation carried from decode to the execute stage
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_ADDI,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_ANDI,
        ALU_CONST,
        ALU_HICONST,
        ALU_NOP
    } alu_op_e;

endpackage
